// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_master_trig
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
trig_word_pkg.sv
run_pkg.sv
trig_word_decode.sv
trig_capture.sv
run_sequencer.sv
trig_decision.sv
master_trig_top.sv
master_trig_properties.sv
tb_master_trig.sv

// ==== master_trig_properties.sv ====
`timescale 1ns/1ns
module master_trig_properties (
    input logic sysclk_i,
    input logic runrst_i,
    input logic trig_i,
    input logic holdoff_i,
    input logic photoshutter_i
);

    // holdoff window and trigger never overlap
    a_trig_outside_holdoff: assert property (
        @(posedge sysclk_i) disable iff (runrst_i) trig_i |-> !holdoff_i
    ) else $error("trig_o high while holdoff_o is high");

    // trigger is a single-cycle pulse
    a_trig_one_cycle: assert property (
        @(posedge sysclk_i) disable iff (runrst_i) trig_i |=> !trig_i
    ) else $error("trig_o high for more than one cycle");

    // shutter only right behind a trigger
    a_photo_after_trig: assert property (
        @(posedge sysclk_i) disable iff (runrst_i) photoshutter_i |-> $past(trig_i)
    ) else $error("photoshutter_o without trig_o one cycle earlier");

endmodule

bind trig_decision master_trig_properties i_properties (
    .sysclk_i       (sysclk_i),
    .runrst_i       (runrst_i),
    .trig_i         (trig_o),
    .holdoff_i      (holdoff_o),
    .photoshutter_i (photoshutter_o)
);

// ==== master_trig_top.sv ====
`timescale 1ns/1ns
module master_trig_top
    import trig_word_pkg::*;
    import run_pkg::*;
#(
    parameter int N_CHAN    = 4,
    parameter int ADDR_BITS = 6
) (
    input  logic                    sysclk_i,
    input  logic                    runrst_i,
    input  logic                    runstop_i,
    input  trig_word_t [N_CHAN-1:0] trigin_dat_i,
    input  logic                    trigin_dat_valid_i,
    input  logic [N_CHAN-1:0]       trig_mask_i,
    input  cfg_word_t               trig_latency_i,
    input  cfg_word_t               trig_offset_i,
    input  cfg_word_t               trig_holdoff_i,
    input  cfg_word_t               photo_prescale_i,
    input  logic                    photo_en_i,
    output logic                    running_o,
    output logic [ADDR_BITS-1:0]    cur_addr_o,
    output logic [N_CHAN-1:0]       scal_trig_o,
    output logic                    trig_o,
    output logic [ADDR_BITS-1:0]    trig_addr_o,
    output logic                    holdoff_o,
    output logic                    photoshutter_o
);

    logic                 running;
    logic                 rd_en;
    logic [ADDR_BITS-1:0] rd_addr;
    logic [N_CHAN-1:0]    rd_flags;

    // hit decode and ring buffer, writes only while running
    trig_capture #(
        .N_CHAN    (N_CHAN),
        .ADDR_BITS (ADDR_BITS)
    ) i_capture (
        .sysclk_i           (sysclk_i),
        .runrst_i           (runrst_i),
        .trigin_dat_i       (trigin_dat_i),
        .trigin_dat_valid_i (trigin_dat_valid_i),
        .wr_en_i            (running),
        .rd_en_i            (rd_en),
        .rd_addr_i          (rd_addr),
        .scal_trig_o        (scal_trig_o),
        .rd_flags_o         (rd_flags)
    );

    // ring timing
    run_sequencer #(
        .ADDR_BITS (ADDR_BITS)
    ) i_sequencer (
        .sysclk_i       (sysclk_i),
        .runrst_i       (runrst_i),
        .runstop_i      (runstop_i),
        .trig_latency_i (trig_latency_i),
        .running_o      (running),
        .cur_addr_o     (cur_addr_o),
        .rd_en_o        (rd_en),
        .rd_addr_o      (rd_addr)
    );

    // level two
    trig_decision #(
        .N_CHAN    (N_CHAN),
        .ADDR_BITS (ADDR_BITS)
    ) i_decision (
        .sysclk_i         (sysclk_i),
        .runrst_i         (runrst_i),
        .running_i        (running),
        .rd_valid_i       (rd_en),
        .rd_addr_i        (rd_addr),
        .rd_flags_i       (rd_flags),
        .trig_mask_i      (trig_mask_i),
        .trig_offset_i    (trig_offset_i),
        .trig_holdoff_i   (trig_holdoff_i),
        .photo_prescale_i (photo_prescale_i),
        .photo_en_i       (photo_en_i),
        .trig_o           (trig_o),
        .trig_addr_o      (trig_addr_o),
        .holdoff_o        (holdoff_o),
        .photoshutter_o   (photoshutter_o)
    );

    assign running_o = running;

endmodule

// ==== run_pkg.sv ====
// run configuration and run state
package run_pkg;

    // latency, offset, holdoff and prescale all share this width
    typedef logic [15:0] cfg_word_t;

    // run state machine
    // wait for the latency to expire, then read out until stopped
    typedef enum logic [1:0] {
        RUN_WAIT_LATENCY = 2'd0,
        RUN_READOUT      = 2'd1,
        RUN_STOPPED      = 2'd2
    } run_state_t;

endpackage

// ==== run_sequencer.sv ====
`timescale 1ns/1ns
module run_sequencer
    import run_pkg::*;
#(
    parameter int ADDR_BITS = 6
) (
    input  logic                 sysclk_i,
    input  logic                 runrst_i,
    input  logic                 runstop_i,
    input  cfg_word_t            trig_latency_i,
    output logic                 running_o,
    output logic [ADDR_BITS-1:0] cur_addr_o,
    output logic                 rd_en_o,
    output logic [ADDR_BITS-1:0] rd_addr_o
);

    run_state_t           state_q;
    cfg_word_t            latency_q;
    cfg_word_t            lat_cnt_q;
    logic [ADDR_BITS-1:0] cur_addr_q;
    logic [ADDR_BITS-1:0] rd_addr_q;
    logic                 lat_done;

    // counter holds the cycles already spent since release
    // a latency of 0 behaves like 1
    assign lat_done = (lat_cnt_q + cfg_word_t'(1)) >= latency_q;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            // reset starts the run and takes the latency
            state_q    <= RUN_WAIT_LATENCY;
            latency_q  <= trig_latency_i;
            lat_cnt_q  <= '0;
            cur_addr_q <= '0;
            rd_addr_q  <= '0;
        end else begin
            case (state_q)
                RUN_WAIT_LATENCY: begin
                    if (runstop_i) begin
                        state_q <= RUN_STOPPED;
                    end else begin
                        cur_addr_q <= cur_addr_q + 1'b1;
                        lat_cnt_q  <= lat_cnt_q + 1'b1;
                        // readout trails the write side by exactly the latency
                        if (lat_done) begin
                            state_q <= RUN_READOUT;
                        end
                    end
                end
                RUN_READOUT: begin
                    if (runstop_i) begin
                        state_q <= RUN_STOPPED;
                    end else begin
                        cur_addr_q <= cur_addr_q + 1'b1;
                        rd_addr_q  <= rd_addr_q + 1'b1;
                    end
                end
                // stopped, or a bad encoding, waits here for reset
                default: state_q <= RUN_STOPPED;
            endcase
        end
    end

    assign running_o  = (state_q != RUN_STOPPED);
    assign rd_en_o    = (state_q == RUN_READOUT);
    assign cur_addr_o = cur_addr_q;
    assign rd_addr_o  = rd_addr_q;

endmodule

// ==== tb_master_trig.sv ====
`timescale 1ns/1ns
module tb_master_trig;
    import trig_word_pkg::*;
    import run_pkg::*;

    localparam int N_CHAN    = 4;
    localparam int ADDR_BITS = 6;
    localparam int LATENCY   = 16;
    localparam int OFFSET    = 3;
    // a row needs at most one ring turn plus the latency to reach the readout
    localparam int TRIG_WAIT = LATENCY + 64 + 16;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [N_CHAN-1:0]    chan_vec_t;

    logic                    sysclk_i = 1'b0;
    logic                    runrst_i;
    logic                    runstop_i;
    trig_word_t [N_CHAN-1:0] trigin_dat_i;
    logic                    trigin_dat_valid_i;
    chan_vec_t               trig_mask_i;
    cfg_word_t               trig_latency_i;
    cfg_word_t               trig_offset_i;
    cfg_word_t               trig_holdoff_i;
    cfg_word_t               photo_prescale_i;
    logic                    photo_en_i;
    logic                    running_o;
    addr_t                   cur_addr_o;
    chan_vec_t               scal_trig_o;
    logic                    trig_o;
    addr_t                   trig_addr_o;
    logic                    holdoff_o;
    logic                    photoshutter_o;

    master_trig_top #(
        .N_CHAN    (N_CHAN),
        .ADDR_BITS (ADDR_BITS)
    ) i_master_trig_top (
        .sysclk_i           (sysclk_i),
        .runrst_i           (runrst_i),
        .runstop_i          (runstop_i),
        .trigin_dat_i       (trigin_dat_i),
        .trigin_dat_valid_i (trigin_dat_valid_i),
        .trig_mask_i        (trig_mask_i),
        .trig_latency_i     (trig_latency_i),
        .trig_offset_i      (trig_offset_i),
        .trig_holdoff_i     (trig_holdoff_i),
        .photo_prescale_i   (photo_prescale_i),
        .photo_en_i         (photo_en_i),
        .running_o          (running_o),
        .cur_addr_o         (cur_addr_o),
        .scal_trig_o        (scal_trig_o),
        .trig_o             (trig_o),
        .trig_addr_o        (trig_addr_o),
        .holdoff_o          (holdoff_o),
        .photoshutter_o     (photoshutter_o)
    );

    // 40 ns period
    always #20 sysclk_i = ~sysclk_i;

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flags(input string name, input chan_vec_t got, input chan_vec_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // flag in the top bit, address from bit 2 upward
    function automatic trig_word_t make_word(input addr_t a);
        trig_word_t w;
        w = '0;
        w[TRIG_FLAG_BIT] = 1'b1;
        w[WORD_ADDR_LSB +: ADDR_BITS] = a;
        return w;
    endfunction

    // address a few slots ahead of the write side
    function automatic addr_t ahead_addr();
        return addr_t'(cur_addr_o + 2 + ($urandom % 7));
    endfunction

    // reset also latches the run parameters
    task automatic apply_reset(input cfg_word_t holdoff);
        @(negedge sysclk_i);
        runrst_i           = 1'b1;
        runstop_i          = 1'b0;
        trigin_dat_valid_i = 1'b0;
        trigin_dat_i       = '0;
        trig_mask_i        = '0;
        trig_holdoff_i     = holdoff;
        repeat (10) @(negedge sysclk_i);
        runrst_i = 1'b0;
        repeat (2) @(negedge sysclk_i);
    endtask

    // one valid cycle for whatever words are loaded, then the bus goes quiet
    task automatic send_word(input int unsigned chan, input addr_t a);
        trigin_dat_i[chan] = make_word(a);
        trigin_dat_valid_i = 1'b1;
        @(negedge sysclk_i);
        trigin_dat_valid_i = 1'b0;
        trigin_dat_i       = '0;
    endtask

    task automatic wait_trig(input int limit, output logic found, output addr_t addr);
        int n;
        n     = 0;
        found = 1'b0;
        addr  = '0;
        while (!found && n < limit) begin
            @(negedge sysclk_i);
            n++;
            if (trig_o) begin
                found = 1'b1;
                addr  = trig_addr_o;
            end
        end
    endtask

    task automatic expect_trig(input addr_t word_addr);
        logic  found;
        addr_t addr;
        wait_trig(TRIG_WAIT, found, addr);
        if (!found) begin
            $display("no trig_o within %0d cycles of the word", TRIG_WAIT);
            stop_on_error();
        end
        // readout address corrected by the offset
        check_addr("trig_addr_o", addr, addr_t'(word_addr - OFFSET));
    endtask

    task automatic expect_no_trig();
        logic  found;
        addr_t addr;
        wait_trig(TRIG_WAIT, found, addr);
        check_bit("trig_o", found, 1'b0);
    endtask

    // one-cycle strobes, so a bit seen twice means a second hit
    task automatic collect_hits(output chan_vec_t once, output chan_vec_t twice);
        once  = '0;
        twice = '0;
        for (int i = 0; i < 12; i++) begin
            @(negedge sysclk_i);
            twice = twice | (once & scal_trig_o);
            once  = once | scal_trig_o;
        end
    endtask

    task automatic test_single_trigger();
        int unsigned chan;
        addr_t       a;
        apply_reset(16'd0);
        chan = $urandom % N_CHAN;
        a    = ahead_addr();
        send_word(chan, a);
        expect_trig(a);
        // row was cleared on read, so nothing comes back a turn later
        expect_no_trig();
    endtask

    task automatic test_hit_strobes();
        int unsigned chan;
        chan_vec_t   once;
        chan_vec_t   twice;
        apply_reset(16'd0);
        chan = $urandom % N_CHAN;
        // second word lands while the first is still pending
        send_word(chan, ahead_addr());
        send_word(chan, ahead_addr());
        collect_hits(once, twice);
        check_flags("scal_trig_o", once, chan_vec_t'(1 << chan));
        check_flags("scal_trig_o repeat", twice, '0);
        // decoder is free again
        send_word(chan, ahead_addr());
        collect_hits(once, twice);
        check_flags("scal_trig_o", once, chan_vec_t'(1 << chan));
    endtask

    task automatic test_mask();
        int unsigned chan;
        addr_t       a;
        apply_reset(16'd0);
        chan        = $urandom % N_CHAN;
        trig_mask_i = chan_vec_t'(1 << chan);
        send_word(chan, ahead_addr());
        expect_no_trig();
        a = ahead_addr();
        send_word((chan + 1) % N_CHAN, a);
        expect_trig(a);
        trig_mask_i = '0;
    endtask

    task automatic test_holdoff(input int unsigned gap, input logic second);
        int unsigned chan;
        addr_t       a;
        apply_reset(16'd20);
        chan = $urandom % N_CHAN;
        a    = ahead_addr();
        // two links in the same cycle, rows gap apart
        trigin_dat_i[(chan + 1) % N_CHAN] = make_word(addr_t'(a + gap));
        send_word(chan, a);
        expect_trig(a);
        @(negedge sysclk_i);
        check_bit("holdoff_o", holdoff_o, 1'b1);
        if (second) begin
            expect_trig(addr_t'(a + gap));
            @(negedge sysclk_i);
            check_bit("holdoff_o", holdoff_o, 1'b1);
        end else begin
            expect_no_trig();
        end
    endtask

    task automatic test_prescale();
        addr_t a;
        apply_reset(16'd0);
        for (int i = 1; i <= 6; i++) begin
            a = ahead_addr();
            send_word($urandom % N_CHAN, a);
            expect_trig(a);
            // shutter follows every third trigger by one cycle
            @(negedge sysclk_i);
            check_bit("photoshutter_o", photoshutter_o, (i % 3) == 0);
        end
    endtask

    task automatic test_runstop();
        addr_t frozen;
        apply_reset(16'd0);
        // stop once the readout is already running
        repeat (LATENCY + 4) @(negedge sysclk_i);
        check_bit("running_o", running_o, 1'b1);
        runstop_i = 1'b1;
        @(negedge sysclk_i);
        runstop_i = 1'b0;
        check_bit("running_o", running_o, 1'b0);
        frozen = cur_addr_o;
        send_word($urandom % N_CHAN, ahead_addr());
        expect_no_trig();
        check_addr("cur_addr_o", cur_addr_o, frozen);
        check_bit("running_o", running_o, 1'b0);
    endtask

    initial begin
        runrst_i           = 1'b1;
        runstop_i          = 1'b0;
        trigin_dat_i       = '0;
        trigin_dat_valid_i = 1'b0;
        trig_mask_i        = '0;
        trig_latency_i     = cfg_word_t'(LATENCY);
        trig_offset_i      = cfg_word_t'(OFFSET);
        trig_holdoff_i     = '0;
        photo_prescale_i   = 16'd2;
        photo_en_i         = 1'b1;
        void'($urandom(29));
        test_single_trigger();
        test_hit_strobes();
        test_mask();
        test_holdoff(5, 1'b0);
        test_holdoff(40, 1'b1);
        test_prescale();
        test_runstop();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== trig_capture.sv ====
`timescale 1ns/1ns
module trig_capture
    import trig_word_pkg::*;
#(
    parameter int N_CHAN    = 4,
    parameter int ADDR_BITS = 6
) (
    input  logic                      sysclk_i,
    input  logic                      runrst_i,
    input  trig_word_t [N_CHAN-1:0]   trigin_dat_i,
    input  logic                      trigin_dat_valid_i,
    input  logic                      wr_en_i,
    input  logic                      rd_en_i,
    input  logic [ADDR_BITS-1:0]      rd_addr_i,
    output logic [N_CHAN-1:0]         scal_trig_o,
    output logic [N_CHAN-1:0]         rd_flags_o
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    logic [N_CHAN-1:0]    hit;
    logic [ADDR_BITS-1:0] hit_addr [N_CHAN];
    // one row per ring address, one bit per link
    logic [N_CHAN-1:0]    flags_q [DEPTH];
    logic [N_CHAN-1:0]    rd_flags_q;

    // one decoder per link
    for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
        trig_word_decode #(
            .ADDR_BITS (ADDR_BITS)
        ) i_decode (
            .sysclk_i     (sysclk_i),
            .runrst_i     (runrst_i),
            .word_i       (trigin_dat_i[c]),
            .word_valid_i (trigin_dat_valid_i),
            .hit_o        (hit[c]),
            .hit_addr_o   (hit_addr[c])
        );
    end

    // ring starts empty so hits left from an earlier run never fire
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            for (int a = 0; a < DEPTH; a++) begin
                flags_q[a] <= '0;
            end
            rd_flags_q <= '0;
        end else begin
            // read and clear, so the row is free when the ring wraps
            if (rd_en_i) begin
                rd_flags_q         <= flags_q[rd_addr_i];
                flags_q[rd_addr_i] <= '0;
            end
            // writes come later in the block, so they win over the clear
            for (int c = 0; c < N_CHAN; c++) begin
                if (wr_en_i && hit[c]) begin
                    flags_q[hit_addr[c]][c] <= 1'b1;
                end
            end
        end
    end

    // scalers see every hit, running or not
    assign scal_trig_o = hit;
    assign rd_flags_o  = rd_flags_q;

endmodule

// ==== trig_decision.sv ====
`timescale 1ns/1ns
module trig_decision
    import run_pkg::*;
#(
    parameter int N_CHAN    = 4,
    parameter int ADDR_BITS = 6
) (
    input  logic                 sysclk_i,
    input  logic                 runrst_i,
    input  logic                 running_i,
    input  logic                 rd_valid_i,
    input  logic [ADDR_BITS-1:0] rd_addr_i,
    input  logic [N_CHAN-1:0]    rd_flags_i,
    input  logic [N_CHAN-1:0]    trig_mask_i,
    input  cfg_word_t            trig_offset_i,
    input  cfg_word_t            trig_holdoff_i,
    input  cfg_word_t            photo_prescale_i,
    input  logic                 photo_en_i,
    output logic                 trig_o,
    output logic [ADDR_BITS-1:0] trig_addr_o,
    output logic                 holdoff_o,
    output logic                 photoshutter_o
);

    logic                 rd_valid_q;
    logic [ADDR_BITS-1:0] rd_addr_q;
    cfg_word_t            offset_q;
    cfg_word_t            holdoff_q;
    cfg_word_t            prescale_q;
    logic                 photo_en_q;
    cfg_word_t            hold_cnt_q;
    cfg_word_t            photo_cnt_q;
    logic [N_CHAN-1:0]    live_flags;
    logic                 any_hit;
    logic                 blocked;
    logic                 fire;
    logic                 trig_q;
    logic [ADDR_BITS-1:0] trig_addr_q;
    logic                 photo_q;

    // mask is live, a set bit drops that link
    assign live_flags = rd_flags_i & ~trig_mask_i;
    assign any_hit    = rd_valid_q && (|live_flags);
    // the trigger cycle itself also blocks, so trig_o stays one cycle wide
    assign blocked    = trig_q || (hold_cnt_q != '0);
    assign fire       = any_hit && running_i && !blocked;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            // run parameters are taken at reset
            offset_q    <= trig_offset_i;
            holdoff_q   <= trig_holdoff_i;
            prescale_q  <= photo_prescale_i;
            photo_en_q  <= photo_en_i;
            rd_valid_q  <= 1'b0;
            hold_cnt_q  <= '0;
            photo_cnt_q <= '0;
            trig_q      <= 1'b0;
            photo_q     <= 1'b0;
        end else begin
            // read strobe lines up with the returned row
            rd_valid_q <= rd_valid_i;
            trig_q     <= fire;
            // holdoff runs for H cycles counting the one after the trigger
            if (trig_q) begin
                hold_cnt_q <= (holdoff_q == '0) ? '0 : holdoff_q - 1'b1;
            end else if (hold_cnt_q != '0) begin
                hold_cnt_q <= hold_cnt_q - 1'b1;
            end
            // every (P+1)-th trigger opens the shutter
            photo_q <= 1'b0;
            if (trig_q) begin
                if (photo_cnt_q >= prescale_q) begin
                    photo_cnt_q <= '0;
                    photo_q     <= photo_en_q;
                end else begin
                    photo_cnt_q <= photo_cnt_q + 1'b1;
                end
            end
        end
    end

    // address path, follows the row and holds the last trigger
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            rd_addr_q   <= '0;
            trig_addr_q <= '0;
        end else begin
            rd_addr_q <= rd_addr_i;
            if (fire) begin
                trig_addr_q <= rd_addr_q - offset_q[ADDR_BITS-1:0];
            end
        end
    end

    assign trig_o         = trig_q;
    assign trig_addr_o    = trig_addr_q;
    assign holdoff_o      = (hold_cnt_q != '0);
    assign photoshutter_o = photo_q;

endmodule

// ==== trig_word_decode.sv ====
`timescale 1ns/1ns
module trig_word_decode
    import trig_word_pkg::*;
#(
    parameter int ADDR_BITS = 6
) (
    input  logic                 sysclk_i,
    input  logic                 runrst_i,
    input  trig_word_t           word_i,
    input  logic                 word_valid_i,
    output logic                 hit_o,
    output logic [ADDR_BITS-1:0] hit_addr_o
);

    logic                 accept;
    logic                 pending_q;
    logic [HIT_DELAY-1:0] delay_q;
    logic                 hit_q;
    logic [ADDR_BITS-1:0] addr_q;

    // only one word in flight per link, later ones are dropped
    assign accept = word_valid_i && word_i[TRIG_FLAG_BIT] && !pending_q;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            pending_q <= 1'b0;
            delay_q   <= '0;
            hit_q     <= 1'b0;
        end else begin
            // acceptance walks down the delay line
            delay_q <= {delay_q[HIT_DELAY-2:0], accept};
            // hit lands HIT_DELAY edges after acceptance
            hit_q   <= delay_q[HIT_DELAY-1];
            // decoder frees up once the hit has gone out
            if (accept) begin
                pending_q <= 1'b1;
            end else if (hit_q) begin
                pending_q <= 1'b0;
            end
        end
    end

    // address is held until the next accepted word
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            addr_q <= '0;
        end else if (accept) begin
            addr_q <= word_i[WORD_ADDR_LSB +: ADDR_BITS];
        end
    end

    assign hit_o      = hit_q;
    assign hit_addr_o = addr_q;

endmodule

// ==== trig_word_pkg.sv ====
// format of one trigger word as it arrives from a link
package trig_word_pkg;

    // one 16-bit word per link per valid strobe
    typedef logic [15:0] trig_word_t;

    // set when the word carries a trigger
    localparam int TRIG_FLAG_BIT = 15;

    // address field starts here and runs upward for ADDR_BITS bits
    // the two bits below it carry nothing useful
    localparam int WORD_ADDR_LSB = 2;

    // edges from accepting a word to its hit strobe
    localparam int HIT_DELAY = 3;

endpackage
